// File: verilog.f
geom_pkg.sv
bus_pkg.sv
tri_cmd_regs.sv
line_draw.sv
pix_write_arb.sv
tri_raster_top.sv
tb_tri_raster.sv

// File: tb_tri_raster.sv
/*
 * testbench for the triangle outline rasterizer
 * host driver, framebuffer model with random ack delay, reference Bresenham edges
 */

module tb_tri_raster
    import geom_pkg::*;
    import bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FB_WIDTH  = 320;
    localparam int FB_HEIGHT = 240;
    localparam int FB_PIX    = FB_WIDTH * FB_HEIGHT;
    localparam int FB_AW     = $clog2(FB_PIX);
    localparam int N_TRI     = 7;

    logic               clk_pix;
    logic               rst_n;
    logic               host_cyc;
    logic               host_stb;
    logic               host_we;
    logic [HOST_AW-1:0] host_adr;
    logic [WB_DW-1:0]   host_dat_w;
    logic [WB_DW-1:0]   host_dat_r;
    logic               host_ack;
    logic               fb_cyc;
    logic               fb_stb;
    logic               fb_we;
    logic [FB_AW-1:0]   fb_adr;
    logic [WB_DW-1:0]   fb_dat_w;
    logic               fb_ack = 1'b0;
    logic               draw_done;

    // x0 y0 x1 y1 x2 y2 colour
    int tri_v [N_TRI][7] = '{
        '{ 10,  10, 100,  40,  30,  90,  5},
        '{300,   5, 160, 200, 250, 230,  9},
        '{  0,   0, 319, 239,   0, 239, 15},
        '{ 77,  88,  77,  88,  77,  88,  3},  // degenerate
        '{ 40, 150, 120, 150,  40, 220,  7},  // horizontal and vertical edges
        '{280, 200, 420, 210, 300, 300, 12},  // past right and bottom
        '{500, 500, 310, 230, 200, 480,  1}
    };

    bit          exp_map [FB_PIX];
    int unsigned hits [FB_PIX];
    int          exp_list [$];  // expected addresses of the current triangle
    logic [31:0] rng = 32'h974a;
    colr_t       cur_colr;
    int          go_count;
    int          done_count = 0;
    int          cycles = 0;
    int          cycle_limit;
    int          ack_wait = 0;
    bit          in_wait = 1'b0;

    tri_raster_top #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) tri_raster_top_inst (.*);

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic expect_val(input string name, input int got, input int exp);
        assert (got == exp) else
            stop_with_error($sformatf("mismatch at time %0t: %s expected %0h, got %0h",
                                      $time, name, exp, got));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // a Bresenham line covers max(|dx|,|dy|)+1 pixels
    function automatic int edge_len(input int x0, input int y0, input int x1, input int y1);
        int ax;
        int ay;
        ax = (x1 > x0) ? x1 - x0 : x0 - x1;
        ay = (y1 > y0) ? y1 - y0 : y0 - y1;
        return ((ax > ay) ? ax : ay) + 1;
    endfunction

    function automatic void plot_ref_edge(input int x0, input int y0, input int x1, input int y1);
        int dx;
        int dy;
        int sx;
        int sy;
        int err;
        int e2;
        int x;
        int y;
        bit fin;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // negative magnitude
        sx  = (x0 < x1) ? 1 : -1;
        sy  = (y0 < y1) ? 1 : -1;
        err = dx + dy;
        x   = x0;
        y   = y0;
        fin = 1'b0;
        while (!fin) begin
            if (x < FB_WIDTH && y < FB_HEIGHT) begin  // off-screen pixels are clipped
                exp_map[y * FB_WIDTH + x] = 1'b1;
                exp_list.push_back(y * FB_WIDTH + x);
            end
            if (x == x1 && y == y1) begin
                fin = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    x   += sx;
                end
                if (e2 <= dx) begin
                    err += dx;
                    y   += sy;
                end
            end
        end
    endfunction

    function automatic logic [WB_DW-1:0] vert_word(input int x, input int y);
        host_word_u w;
        w.vert[0] = 16'(x);
        w.vert[1] = 16'(y);
        return w;
    endfunction

    task automatic host_write(input logic [HOST_AW-1:0] adr, input logic [WB_DW-1:0] dat);
        @(negedge clk_pix);
        host_cyc   = 1'b1;
        host_stb   = 1'b1;
        host_we    = 1'b1;
        host_adr   = adr;
        host_dat_w = dat;
        do begin
            @(negedge clk_pix);
        end while (!host_ack);
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic host_read(input logic [HOST_AW-1:0] adr, output logic [WB_DW-1:0] dat);
        @(negedge clk_pix);
        host_cyc = 1'b1;
        host_stb = 1'b1;
        host_we  = 1'b0;
        host_adr = adr;
        do begin
            @(negedge clk_pix);
        end while (!host_ack);
        dat      = host_dat_r;
        host_cyc = 1'b0;
        host_stb = 1'b0;
    endtask

    task automatic record_write();
        assert (fb_adr < FB_PIX) else
            stop_with_error($sformatf("write to address %0d outside the framebuffer", fb_adr));
        assert (exp_map[fb_adr]) else
            stop_with_error($sformatf("write to pixel %0d,%0d which lies on no edge",
                                      fb_adr % FB_WIDTH, fb_adr / FB_WIDTH));
        expect_val("fb_dat_w", fb_dat_w, cur_colr);
        hits[fb_adr]++;
    endtask

    // framebuffer slave, acks 0 to 3 cycles late
    always @(negedge clk_pix) begin
        if (fb_ack) begin
            fb_ack = 1'b0;
        end else if (fb_cyc && fb_stb) begin
            if (!in_wait) begin
                rng      = xorshift(rng);
                ack_wait = int'(rng[1:0]);
                in_wait  = 1'b1;
            end
            if (ack_wait == 0) begin
                record_write();
                fb_ack  = 1'b1;
                in_wait = 1'b0;
            end else begin
                ack_wait--;
            end
        end
    end

    always @(negedge clk_pix) begin
        if (draw_done) done_count++;
    end

    always @(posedge clk_pix) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            stop_with_error($sformatf("timeout, no finish after %0d cycles", cycles));
        end
    end

    a_fb_write_only: assert property (@(posedge clk_pix) disable iff (!rst_n)
        fb_cyc |-> fb_we)
        else stop_with_error("fb_we was low during a framebuffer cycle");

    a_fb_stb_held: assert property (@(posedge clk_pix) disable iff (!rst_n)
        fb_stb && !fb_ack |=> fb_stb && $stable(fb_adr) && $stable(fb_dat_w))
        else stop_with_error("framebuffer request changed or dropped before its ack");

    a_host_ack_next: assert property (@(posedge clk_pix) disable iff (!rst_n)
        host_cyc && host_stb && !host_ack |=> host_ack)
        else stop_with_error("host request was not acked on the next cycle");

    a_host_ack_once: assert property (@(posedge clk_pix) disable iff (!rst_n)
        host_ack |=> !host_ack)
        else stop_with_error("host ack stayed high for more than one cycle");

    a_done_pulse: assert property (@(posedge clk_pix) disable iff (!rst_n)
        draw_done |=> !draw_done)
        else stop_with_error("draw_done stayed high for more than one cycle");

    task automatic run_triangle(input int t, input bit poke);
        host_word_u  w;
        logic [31:0] rd;
        exp_list.delete();
        foreach (exp_map[i]) begin
            exp_map[i] = 1'b0;
            hits[i]    = 0;
        end
        for (int e = 0; e < N_EDGE; e++) begin
            plot_ref_edge(tri_v[t][2*e], tri_v[t][2*e+1],
                          tri_v[t][(2*e+2)%6], tri_v[t][(2*e+3)%6]);
        end
        cur_colr = colr_t'(tri_v[t][6]);
        for (int v = 0; v < N_EDGE; v++) begin
            host_write(HOST_AW'(v), vert_word(tri_v[t][2*v], tri_v[t][2*v+1]));
        end
        w            = '0;
        w.attr[0]    = 8'(cur_colr);
        w.attr[1][0] = 1'b1;  // go
        host_write(REG_ATTR, w);
        go_count++;
        host_read(REG_ATTR, rd);
        expect_val("host_dat_r[0]", rd[0], 1);
        if (poke) begin  // all ignored while busy
            for (int v = 0; v < N_EDGE; v++) begin
                host_write(HOST_AW'(v), vert_word(v + 1, v + 2));
            end
            w.attr[0] = 8'(~cur_colr);
            host_write(REG_ATTR, w);
        end
        do begin
            @(negedge clk_pix);
        end while (!draw_done);
        foreach (exp_list[i]) begin
            assert (hits[exp_list[i]] > 0) else
                stop_with_error($sformatf("edge pixel %0d,%0d of triangle %0d was never written",
                                          exp_list[i] % FB_WIDTH, exp_list[i] / FB_WIDTH, t));
        end
        host_read(REG_ATTR, rd);
        expect_val("host_dat_r[0]", rd[0], 0);
        expect_val("draw_done count", done_count, go_count);
        if (poke) begin
            for (int v = 0; v < N_EDGE; v++) begin
                host_read(HOST_AW'(v), rd);
                expect_val("host_dat_r", rd, vert_word(tri_v[t][2*v], tri_v[t][2*v+1]));
            end
        end
    endtask

    initial begin
        int total;
        total = 0;
        for (int t = 0; t < N_TRI; t++) begin
            for (int e = 0; e < N_EDGE; e++) begin
                total += edge_len(tri_v[t][2*e], tri_v[t][2*e+1],
                                  tri_v[t][(2*e+2)%6], tri_v[t][(2*e+3)%6]);
            end
        end
        cycle_limit = 20 * total + 2000;
        rst_n       = 1'b0;
        host_cyc    = 1'b0;
        host_stb    = 1'b0;
        host_we     = 1'b0;
        host_adr    = '0;
        host_dat_w  = '0;
        go_count    = 0;
        repeat (4) @(negedge clk_pix);
        expect_val("host_ack", host_ack, 0);
        expect_val("fb_cyc", fb_cyc, 0);
        expect_val("fb_stb", fb_stb, 0);
        expect_val("draw_done", draw_done, 0);
        rst_n = 1'b1;
        for (int t = 0; t < N_TRI; t++) begin
            run_triangle(t, t == 0 || t == 5);
        end
        repeat (50) @(negedge clk_pix);  // no stray triangle may follow
        if (done_count == go_count && !fb_cyc) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_with_error($sformatf("mismatch at time %0t: draw_done count expected %0d, got %0d",
                                      $time, go_count, done_count));
        end
    end

endmodule

// File: tri_raster_top.sv
/*
 * triangle outline rasterizer top level
 * command registers, three edge drawers and the framebuffer write arbiter
 */

module tri_raster_top
    import geom_pkg::*;
    import bus_pkg::*;
#(
    parameter int   FB_WIDTH  = 320,
    parameter int   FB_HEIGHT = 240,
    localparam int  FB_AW     = $clog2(FB_WIDTH * FB_HEIGHT)
) (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  logic               host_cyc,
    input  logic               host_stb,
    input  logic               host_we,
    input  logic [HOST_AW-1:0] host_adr,
    input  logic [WB_DW-1:0]   host_dat_w,
    output logic [WB_DW-1:0]   host_dat_r,
    output logic               host_ack,
    output logic               fb_cyc,
    output logic               fb_stb,
    output logic               fb_we,
    output logic [FB_AW-1:0]   fb_adr,
    output logic [WB_DW-1:0]   fb_dat_w,
    input  logic               fb_ack,
    output logic               draw_done
);

    logic               edge_start;
    logic               busy;
    colr_t              colr;
    cord_t [N_EDGE-1:0] edge_x0;
    cord_t [N_EDGE-1:0] edge_y0;
    cord_t [N_EDGE-1:0] edge_x1;
    cord_t [N_EDGE-1:0] edge_y1;
    logic [N_EDGE-1:0]  pix_valid;
    logic [N_EDGE-1:0]  pix_ready;
    logic [N_EDGE-1:0]  edge_done;
    cord_t [N_EDGE-1:0] pix_x;
    cord_t [N_EDGE-1:0] pix_y;

    tri_cmd_regs u_cmd (
        .clk_pix,
        .rst_n,
        .host_cyc,
        .host_stb,
        .host_we,
        .host_adr,
        .host_dat_w,
        .draw_done,
        .host_ack,
        .host_dat_r,
        .edge_start,
        .edge_x0,
        .edge_y0,
        .edge_x1,
        .edge_y1,
        .colr,
        .busy
    );

    // one drawer per triangle edge
    for (genvar i = 0; i < N_EDGE; i++) begin : g_edge
        line_draw u_line (
            .clk_pix,
            .rst_n,
            .edge_start,
            .x0        (edge_x0[i]),
            .y0        (edge_y0[i]),
            .x1        (edge_x1[i]),
            .y1        (edge_y1[i]),
            .pix_ready (pix_ready[i]),
            .pix_valid (pix_valid[i]),
            .pix_x     (pix_x[i]),
            .pix_y     (pix_y[i]),
            .edge_done (edge_done[i])
        );
    end

    pix_write_arb #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .FB_AW     (FB_AW)
    ) u_arb (
        .clk_pix,
        .rst_n,
        .pix_valid,
        .pix_x,
        .pix_y,
        .edge_done,
        .colr,
        .busy,
        .fb_ack,
        .pix_ready,
        .fb_cyc,
        .fb_stb,
        .fb_we,
        .fb_adr,
        .fb_dat_w,
        .draw_done
    );

endmodule

// File: pix_write_arb.sv
/*
 * pixel write arbiter
 * round-robin over the edge lanes, clips, and writes through a Wishbone master
 */

module pix_write_arb
    import geom_pkg::*;
    import bus_pkg::*;
#(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240,
    parameter int FB_AW     = 17
) (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  logic [N_EDGE-1:0]  pix_valid,
    input  cord_t [N_EDGE-1:0] pix_x,
    input  cord_t [N_EDGE-1:0] pix_y,
    input  logic [N_EDGE-1:0]  edge_done,
    input  colr_t              colr,
    input  logic               busy,
    input  logic               fb_ack,
    output logic [N_EDGE-1:0]  pix_ready,
    output logic               fb_cyc,
    output logic               fb_stb,
    output logic               fb_we,
    output logic [FB_AW-1:0]   fb_adr,
    output logic [WB_DW-1:0]   fb_dat_w,
    output logic               draw_done
);

    localparam int LW = $clog2(N_EDGE);

    logic [LW-1:0] last_lane;  // lane served last
    logic [LW-1:0] grant;
    logic          any_valid;
    logic          take;       // granted pixel transfers this cycle
    logic          in_range;
    logic          armed;      // lanes have started on this triangle
    cord_t         sel_x;
    cord_t         sel_y;

    // nearest valid lane after the last one wins
    always_comb begin : pick
        int idx;
        grant     = last_lane;
        any_valid = 1'b0;
        for (int k = N_EDGE; k > 0; k--) begin
            idx = (int'(last_lane) + k) % N_EDGE;
            if (pix_valid[idx]) begin
                grant     = LW'(idx);
                any_valid = 1'b1;
            end
        end
    end

    assign take = any_valid && !fb_cyc;  // no new pixel while a write is open

    always_comb begin
        pix_ready        = '0;
        pix_ready[grant] = take;
    end

    assign sel_x    = pix_x[grant];
    assign sel_y    = pix_y[grant];
    assign in_range = (sel_x < FB_WIDTH) && (sel_y < FB_HEIGHT);
    assign fb_we    = fb_cyc;  // write only

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            fb_cyc    <= 1'b0;
            fb_stb    <= 1'b0;
            last_lane <= '0;
            armed     <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            draw_done <= 1'b0;
            if (take) begin
                last_lane <= grant;
                if (in_range) begin  // clipped pixels are just dropped
                    fb_cyc <= 1'b1;
                    fb_stb <= 1'b1;
                end
            end else if (fb_cyc && fb_ack) begin
                fb_cyc <= 1'b0;
                fb_stb <= 1'b0;
            end

            // lanes still show done from the last triangle until they restart
            if (busy && !(&edge_done)) begin
                armed <= 1'b1;
            end
            if (busy && armed && (&edge_done) && !fb_cyc) begin
                draw_done <= 1'b1;
                armed     <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (take && in_range) begin
            fb_adr   <= FB_AW'(sel_y) * FB_AW'(FB_WIDTH) + FB_AW'(sel_x);
            fb_dat_w <= WB_DW'(colr);
        end
    end

    a_stb_until_ack: assert property (@(posedge clk_pix) disable iff (!rst_n)
        fb_stb && !fb_ack |=> fb_stb && $stable(fb_adr) && $stable(fb_dat_w));

endmodule

// File: line_draw.sv
/*
 * Bresenham line drawer, all octants
 * emits one pixel per valid/ready handshake from (x0,y0) to (x1,y1)
 */

module line_draw
    import geom_pkg::*;
(
    input  logic  clk_pix,
    input  logic  rst_n,
    input  logic  edge_start,
    input  cord_t x0,
    input  cord_t y0,
    input  cord_t x1,
    input  cord_t y1,
    input  logic  pix_ready,
    output logic  pix_valid,
    output cord_t pix_x,
    output cord_t pix_y,
    output logic  edge_done
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_INIT = 2'd1;  // first error term
    localparam logic [1:0] S_DRAW = 2'd2;
    localparam logic [1:0] S_DONE = 2'd3;

    logic [1:0]              state;
    cord_t                   x_end;
    cord_t                   y_end;
    logic                    x_neg;   // step direction
    logic                    y_neg;
    logic signed [CORDW:0]   dx;      // |x1 - x0|
    logic signed [CORDW:0]   dy;      // -|y1 - y0|
    logic signed [CORDW+1:0] err;     // can swing past dx on shallow lines
    logic signed [CORDW+2:0] e2;
    logic                    xfer;
    logic                    last;
    logic                    step_x;
    logic                    step_y;

    assign pix_valid = (state == S_DRAW);
    assign edge_done = (state == S_DONE);
    assign xfer      = pix_valid && pix_ready;
    assign last      = (pix_x == x_end) && (pix_y == y_end);
    assign e2        = {err, 1'b0};
    assign step_x    = (e2 >= dy);
    assign step_y    = (e2 <= dx);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_INIT:  state <= S_DRAW;
                S_DRAW:  if (xfer && last) state <= S_DONE;
                default: if (edge_start) state <= S_INIT;  // idle or done
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        case (state)
            S_INIT: err <= dx + dy;
            S_DRAW: begin
                if (xfer && !last) begin  // advance only on a transfer
                    if (step_x) begin
                        pix_x <= x_neg ? pix_x - 1'b1 : pix_x + 1'b1;
                    end
                    if (step_y) begin
                        pix_y <= y_neg ? pix_y - 1'b1 : pix_y + 1'b1;
                    end
                    if (step_x && step_y) begin
                        err <= err + dx + dy;
                    end else if (step_x) begin
                        err <= err + dy;
                    end else begin
                        err <= err + dx;
                    end
                end
            end
            default: begin
                if (edge_start) begin
                    pix_x <= x0;
                    pix_y <= y0;
                    x_end <= x1;
                    y_end <= y1;
                    x_neg <= (x1 < x0);
                    y_neg <= (y1 < y0);
                    dx    <= (x1 < x0) ? x0 - x1 : x1 - x0;
                    dy    <= (y1 < y0) ? y1 - y0 : y0 - y1;  // negative magnitude
                end
            end
        endcase
    end

    a_hold_pixel: assert property (@(posedge clk_pix) disable iff (!rst_n)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_x) && $stable(pix_y));

endmodule

// File: tri_cmd_regs.sv
/*
 * triangle command registers
 * Wishbone classic slave holding three vertices and a colour, starts the edges
 */

module tri_cmd_regs
    import geom_pkg::*;
    import bus_pkg::*;
(
    input  logic                clk_pix,
    input  logic                rst_n,
    input  logic                host_cyc,
    input  logic                host_stb,
    input  logic                host_we,
    input  logic [HOST_AW-1:0]  host_adr,
    input  logic [WB_DW-1:0]    host_dat_w,
    input  logic                draw_done,
    output logic                host_ack,
    output logic [WB_DW-1:0]    host_dat_r,
    output logic                edge_start,
    output cord_t [N_EDGE-1:0]  edge_x0,
    output cord_t [N_EDGE-1:0]  edge_y0,
    output cord_t [N_EDGE-1:0]  edge_x1,
    output cord_t [N_EDGE-1:0]  edge_y1,
    output colr_t               colr,
    output logic                busy
);

    host_word_u         wr_word;  // write data, decoded by offset
    host_word_u         rd_word;
    cord_t [N_EDGE-1:0] vx;
    cord_t [N_EDGE-1:0] vy;
    logic               req;      // new request, not yet acked
    logic               go_acc;   // go accepted, start on next cycle

    assign wr_word = host_dat_w;
    assign req     = host_cyc && host_stb && !host_ack;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            host_ack   <= 1'b0;
            busy       <= 1'b0;
            go_acc     <= 1'b0;
            edge_start <= 1'b0;
            colr       <= '0;
        end else begin
            host_ack   <= req;
            edge_start <= go_acc;  // one cycle after the ack
            go_acc     <= 1'b0;
            if (draw_done) begin
                busy <= 1'b0;
            end
            if (req && host_we && host_adr == REG_ATTR && !busy) begin
                colr <= wr_word.attr[0][COLRW-1:0];
                if (wr_word.attr[1][0]) begin  // go bit
                    busy   <= 1'b1;
                    go_acc <= 1'b1;
                end
            end
        end
    end

    // vertex writes land only while idle
    always_ff @(posedge clk_pix) begin
        if (req && host_we && !busy) begin
            case (host_adr)
                REG_V0, REG_V1, REG_V2: begin
                    vx[host_adr] <= wr_word.vert[0][CORDW-1:0];
                    vy[host_adr] <= wr_word.vert[1][CORDW-1:0];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_word = '0;
        if (host_adr == REG_ATTR) begin
            rd_word.attr[0][0] = busy;
        end else begin
            rd_word.vert[0] = 16'(vx[host_adr]);
            rd_word.vert[1] = 16'(vy[host_adr]);
        end
    end

    always_ff @(posedge clk_pix) begin
        if (req) begin
            host_dat_r <= rd_word;
        end
    end

    // edge i runs from vertex i to the next vertex, wrapping
    always_comb begin
        for (int i = 0; i < N_EDGE; i++) begin
            edge_x0[i] = vx[i];
            edge_y0[i] = vy[i];
            edge_x1[i] = vx[(i + 1) % N_EDGE];
            edge_y1[i] = vy[(i + 1) % N_EDGE];
        end
    end

    a_ack_after_req: assert property (@(posedge clk_pix) disable iff (!rst_n)
        host_ack |-> $past(host_cyc && host_stb));

    // a start lies inside the busy period its go opened
    a_start_from_idle: assert property (@(posedge clk_pix) disable iff (!rst_n)
        edge_start |-> busy);

endmodule

// File: bus_pkg.sv
/*
 * bus definitions for the triangle rasterizer
 * Wishbone data width and host register map (word offsets)
 */

package bus_pkg;

    localparam int WB_DW   = 32;  // Wishbone data width
    localparam int HOST_AW = 2;   // host address, word index

    // host register map
    localparam logic [HOST_AW-1:0] REG_V0   = 2'd0;  // vertex 0
    localparam logic [HOST_AW-1:0] REG_V1   = 2'd1;  // vertex 1
    localparam logic [HOST_AW-1:0] REG_V2   = 2'd2;  // vertex 2
    localparam logic [HOST_AW-1:0] REG_ATTR = 2'd3;  // colour and go, busy on read

endpackage

// File: geom_pkg.sv
/*
 * geometry definitions for the triangle rasterizer
 * screen coordinates, colour index and the host data word views
 */

package geom_pkg;

    localparam int CORDW  = 9;  // one screen coordinate
    localparam int COLRW  = 4;  // colour index bits
    localparam int N_EDGE = 3;  // a triangle has three edges

    typedef logic [CORDW-1:0] cord_t;
    typedef logic [COLRW-1:0] colr_t;

    // One 32-bit host data word, read two ways.
    // The register offset decides which view applies:
    //   vertex    : x in the low half, y in the high half, each zero padded
    //   attribute : colour index in the low bits of byte 0, go at bit 8
    typedef union packed {
        logic [1:0][15:0] vert;  // [0] x, [1] y
        logic [3:0][7:0]  attr;  // [0] colour, [1][0] go, rest reserved
    } host_word_u;

endpackage
